// ==== if_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// control side types of the fetch stage: pc source selects, redirect
// request and the instruction handed to decode
// boot_addr_i and mtvec must be aligned to 2**BootAlign bytes
////////////////////////////////////////////////////////////////////////////

package if_ctrl_pkg;

  // low address bits forced to zero for boot address and mtvec base
  parameter int unsigned BootAlign = 8;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // vector used when the source is PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // redirect request from the decode side, 43 bits
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    logic [4:0]  irq_id;
    logic [31:0] jump_target;
  } pc_ctrl_t;

  // contents of the IF-ID register, 65 bits
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] pc;
    logic        fetch_err;
  } id_instr_t;

endpackage

// ==== if_bus_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction bus types, req/gnt/rvalid handshake with in-order responses
// only word accesses, no byte enables, err is valid together with rvalid
////////////////////////////////////////////////////////////////////////////

package if_bus_pkg;

  // bus requests allowed in flight at once
  parameter int unsigned MaxOutstanding = 2;

  // outward request, held until granted
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } instr_req_t;

  // inward grant and response
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } instr_rsp_t;

  // one fetched word as kept in the prefetch queue
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
  } fetch_entry_t;

endpackage

// ==== if_pc_select.sv ====
////////////////////////////////////////////////////////////////////////////
// next fetch address mux, purely combinational
// mtvec low BootAlign bits are ignored, irq vectors are base + 4*irq_id
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module if_pc_select #(
  parameter int unsigned DmHaltAddr      = 32'h1A11_0800,
  parameter int unsigned DmExceptionAddr = 32'h1A11_0808
) (
  input  if_ctrl_pkg::pc_ctrl_t ctrl_i,
  input  logic [31:0]           boot_addr_i,
  input  logic [31:0]           csr_mtvec_i,
  input  logic [31:0]           csr_mepc_i,
  input  logic [31:0]           csr_depc_i,
  output logic [31:0]           target_o,
  output logic                  mtvec_init_o
);

  logic [31:0] mtvec_base;
  logic [31:0] exc_pc;

  // trap base, low bits cleared
  assign mtvec_base = {csr_mtvec_i[31:if_ctrl_pkg::BootAlign],
                       {if_ctrl_pkg::BootAlign{1'b0}}};

  // exception / interrupt / debug vector
  always_comb begin
    unique case (ctrl_i.exc_pc_mux)
      if_ctrl_pkg::EXC_PC_EXC:     exc_pc = mtvec_base;
      // vectored mode, one word per interrupt id
      if_ctrl_pkg::EXC_PC_IRQ:     exc_pc = mtvec_base + {25'b0, ctrl_i.irq_id, 2'b00};
      if_ctrl_pkg::EXC_PC_DBD:     exc_pc = DmHaltAddr;
      if_ctrl_pkg::EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:                     exc_pc = mtvec_base;
    endcase
  end

  // fetch target
  always_comb begin
    unique case (ctrl_i.pc_mux)
      if_ctrl_pkg::PC_BOOT: target_o = boot_addr_i;
      if_ctrl_pkg::PC_JUMP: target_o = ctrl_i.jump_target;
      if_ctrl_pkg::PC_EXC:  target_o = exc_pc;
      // return from trap
      if_ctrl_pkg::PC_ERET: target_o = csr_mepc_i;
      // return from debug mode
      if_ctrl_pkg::PC_DRET: target_o = csr_depc_i;
      default:              target_o = boot_addr_i;
    endcase
  end

  // csr file loads mtvec from the boot address on the boot jump
  assign mtvec_init_o = ctrl_i.pc_set & (ctrl_i.pc_mux == if_ctrl_pkg::PC_BOOT);

endmodule

// ==== fetch_fifo.sv ====
////////////////////////////////////////////////////////////////////////////
// circular buffer of Depth entries, head shown to the reader
// a write while full is dropped, flush wins over read and write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned Depth     = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       wvalid_i,
  input  payload_t                   wdata_i,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output payload_t                   rdata_o,
  output logic [$clog2(Depth+1)-1:0] count_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wptr_q;
  logic [PtrW-1:0] rptr_q;
  logic [CntW-1:0] count_q;
  logic            wr_en;
  logic            rd_en;

  // wrap at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    ptr_inc = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];
  assign count_o  = count_q;

  assign rd_en = rready_i & rvalid_o;
  assign wr_en = wvalid_i & (count_q != CntW'(Depth));

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (wr_en) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (rd_en) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      count_q <= count_q + CntW'(wr_en) - CntW'(rd_en);
    end
  end

  // storage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en && !flush_i) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

// ==== if_prefetch.sv ====
////////////////////////////////////////////////////////////////////////////
// prefetcher for aligned 32-bit words, up to MaxOutstanding in flight
// requests go out only while outstanding + queued < FifoDepth, so every
// response finds room; responses to requests made before a redirect drop
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module if_prefetch #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     branch_i,
  input  logic [31:0]              branch_addr_i,
  output if_bus_pkg::instr_req_t   bus_req_o,
  input  if_bus_pkg::instr_rsp_t   bus_rsp_i,
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output if_bus_pkg::fetch_entry_t out_o,
  output logic                     busy_o
);

  localparam int unsigned OutW   = $clog2(if_bus_pkg::MaxOutstanding + 1);
  localparam int unsigned QueueW = $clog2(FifoDepth + 1);

  logic [31:0]              fetch_addr_q;
  logic                     req_en_q;
  logic                     hold_q;
  logic [OutW-1:0]          out_cnt_q;
  logic [OutW-1:0]          out_cnt_d;
  logic [OutW-1:0]          stale_cnt_q;
  logic                     credit_ok;
  logic                     grant;
  logic                     rsp_stale;
  logic                     rsp_keep;
  logic                     addr_valid;
  logic [31:0]              rsp_addr;
  logic [QueueW-1:0]        queue_cnt;
  if_bus_pkg::fetch_entry_t rsp_entry;

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  // room for one more word counting both the bus and the queue
  assign credit_ok = ((32'(out_cnt_q) + 32'(queue_cnt)) < FifoDepth) &&
                     (32'(out_cnt_q) < if_bus_pkg::MaxOutstanding);

  // req_i is sampled, an ungranted request stays up except on a redirect
  assign bus_req_o.req  = (req_en_q | hold_q) & credit_ok & ~branch_i;
  assign bus_req_o.addr = fetch_addr_q;
  assign grant          = bus_req_o.req & bus_rsp_i.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_en_q     <= 1'b0;
      hold_q       <= 1'b0;
      fetch_addr_q <= '0;
    end else begin
      req_en_q <= req_i;
      hold_q   <= bus_req_o.req & ~bus_rsp_i.gnt;
      if (branch_i) begin
        // word aligned, low bits dropped
        fetch_addr_q <= {branch_addr_i[31:2], 2'b00};
      end else if (grant) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outstanding and stale tracking
  ////////////////////////////////////////////////////////////////////////////

  assign out_cnt_d = out_cnt_q + OutW'(grant) - OutW'(bus_rsp_i.rvalid);
  assign rsp_stale = (stale_cnt_q != '0);
  // response of a request made after the last redirect
  assign rsp_keep  = bus_rsp_i.rvalid & ~rsp_stale;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_cnt_q   <= '0;
      stale_cnt_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_d;
      if (branch_i) begin
        // everything still in flight after this cycle belongs to the old stream
        stale_cnt_q <= out_cnt_d;
      end else if (bus_rsp_i.rvalid && rsp_stale) begin
        stale_cnt_q <= stale_cnt_q - 1'b1;
      end
    end
  end

  assign busy_o = (out_cnt_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // address record and word queue
  ////////////////////////////////////////////////////////////////////////////

  // addresses of live granted requests, popped by their response
  fetch_fifo #(
    .payload_t (logic [31:0]),
    .Depth     (if_bus_pkg::MaxOutstanding)
  ) addr_fifo_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (branch_i),
    .wvalid_i (grant),
    .wdata_i  (fetch_addr_q),
    .rvalid_o (addr_valid),
    .rready_i (rsp_keep),
    .rdata_o  (rsp_addr),
    .count_o  ()
  );

  assign rsp_entry.rdata = bus_rsp_i.rdata;
  assign rsp_entry.addr  = rsp_addr;
  assign rsp_entry.err   = bus_rsp_i.err;

  // fetched words waiting for decode
  fetch_fifo #(
    .payload_t (if_bus_pkg::fetch_entry_t),
    .Depth     (FifoDepth)
  ) word_fifo_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (branch_i),
    .wvalid_i (rsp_keep & addr_valid),
    .wdata_i  (rsp_entry),
    .rvalid_o (out_valid_o),
    .rready_i (out_ready_i),
    .rdata_o  (out_o),
    .count_o  (queue_cnt)
  );

endmodule

// ==== if_id_reg.sv ====
////////////////////////////////////////////////////////////////////////////
// IF-ID pipeline register, loads when the queue is valid and decode ready
// valid holds until instr_valid_clear_i, a load during pc_set is squashed
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module if_id_reg (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     in_valid_i,
  input  if_bus_pkg::fetch_entry_t in_i,
  output logic                     in_ready_o,
  input  logic                     id_in_ready_i,
  input  logic                     pc_set_i,
  input  logic                     instr_valid_clear_i,
  input  logic                     pmp_err_if_i,
  output logic                     instr_valid_id_o,
  output logic                     instr_new_id_o,
  output if_ctrl_pkg::id_instr_t   id_o
);

  logic                   load;
  logic                   valid_d;
  logic                   valid_q;
  logic                   new_q;
  if_ctrl_pkg::id_instr_t id_q;

  // decode readiness passes straight to the queue
  assign in_ready_o = id_in_ready_i;
  assign load       = in_valid_i & id_in_ready_i;

  // new instruction unless a redirect kills it in the same cycle
  assign valid_d = (load & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  // flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one pulse per load
      new_q   <= load;
    end
  end

  // payload, frozen while decode stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q <= '0;
    end else if (load) begin
      id_q.rdata     <= in_i.rdata;
      id_q.pc        <= in_i.addr;
      // bus error or pmp denial at the fetch address
      id_q.fetch_err <= in_i.err | pmp_err_if_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;
  assign id_o             = id_q;

endmodule

// ==== if_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction fetch stage: pc select, prefetch queue and IF-ID register
// only 32-bit word aligned instructions, a boot pc_set must precede fetch
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module if_stage #(
  parameter int unsigned DmHaltAddr      = 32'h1A11_0800,
  parameter int unsigned DmExceptionAddr = 32'h1A11_0808,
  parameter int unsigned FifoDepth       = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [31:0]            boot_addr_i,
  input  logic                   req_i,
  output if_bus_pkg::instr_req_t instr_req_o,
  input  if_bus_pkg::instr_rsp_t instr_rsp_i,
  input  if_ctrl_pkg::pc_ctrl_t  ctrl_i,
  input  logic [31:0]            csr_mtvec_i,
  input  logic [31:0]            csr_mepc_i,
  input  logic [31:0]            csr_depc_i,
  input  logic                   pmp_err_if_i,
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output if_ctrl_pkg::id_instr_t id_o,
  output logic [31:0]            pc_if_o,
  output logic [31:0]            pc_set_target_o,
  output logic                   csr_mtvec_init_o,
  output logic                   if_busy_o
);

  logic                     fetch_valid;
  logic                     fetch_ready;
  if_bus_pkg::fetch_entry_t fetch_entry;

  ////////////////////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////////////////////

  if_pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) pc_select_i (
    .ctrl_i       (ctrl_i),
    .boot_addr_i  (boot_addr_i),
    .csr_mtvec_i  (csr_mtvec_i),
    .csr_mepc_i   (csr_mepc_i),
    .csr_depc_i   (csr_depc_i),
    .target_o     (pc_set_target_o),
    .mtvec_init_o (csr_mtvec_init_o)
  );

  // prefetch, redirected by pc_set to the selected target
  if_prefetch #(
    .FifoDepth (FifoDepth)
  ) prefetch_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (ctrl_i.pc_set),
    .branch_addr_i (pc_set_target_o),
    .bus_req_o     (instr_req_o),
    .bus_rsp_i     (instr_rsp_i),
    .out_valid_o   (fetch_valid),
    .out_ready_i   (fetch_ready),
    .out_o         (fetch_entry),
    .busy_o        (if_busy_o)
  );

  // pc of the word at the queue head
  assign pc_if_o = fetch_entry.addr;

  ////////////////////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////////////////////

  if_id_reg if_id_reg_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .in_valid_i          (fetch_valid),
    .in_i                (fetch_entry),
    .in_ready_o          (fetch_ready),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (ctrl_i.pc_set),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pmp_err_if_i        (pmp_err_if_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_o                (id_o)
  );

endmodule

// ==== if_stage_asserts.sv ====
////////////////////////////////////////////////////////////////////////////
// bus and redirect rules of the fetch stage, bound into if_stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module if_stage_asserts (
  input logic                   clk_i,
  input logic                   rst_ni,
  input if_bus_pkg::instr_req_t instr_req_o,
  input if_bus_pkg::instr_rsp_t instr_rsp_i,
  input if_ctrl_pkg::pc_ctrl_t  ctrl_i,
  input logic                   instr_valid_clear_i,
  input logic                   instr_valid_id_o,
  input logic                   csr_mtvec_init_o
);

  // ungranted request holds its address unless a redirect drops it
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_o.req && !instr_rsp_i.gnt) |=>
      (ctrl_i.pc_set || (instr_req_o.req && $stable(instr_req_o.addr))))
    else $error("request changed before its grant");

  req_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o.req |-> (instr_req_o.addr[1:0] == 2'b00))
    else $error("request address not word aligned");

  // a load in the redirect cycle never leaves a valid instruction
  squash: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl_i.pc_set && instr_valid_clear_i) |=> !instr_valid_id_o)
    else $error("instruction valid after a redirect");

  mtvec_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o |-> (ctrl_i.pc_set && ctrl_i.pc_mux == if_ctrl_pkg::PC_BOOT))
    else $error("mtvec init without a boot redirect");

endmodule

bind if_stage if_stage_asserts asserts_i (.*);

// ==== tb_if_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// testbench for if_stage, random grant and response delays from an LCG
// memory word is address ^ 32'h5a5a_0000, one page of addresses flags err
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_if_stage;

  localparam logic [31:0] DmHalt    = 32'h1A11_0800;
  localparam logic [31:0] DmExc     = 32'h1A11_0808;
  localparam logic [31:0] DataXor   = 32'h5a5a_0000;
  // 4 KiB page whose fetches return a bus error
  localparam logic [19:0] ErrPage   = 20'h00003;
  localparam int          TotalWords = 71;
  localparam int          MaxCycles  = TotalWords * 12 + 200;

  // one row of the test table
  typedef struct packed {
    if_ctrl_pkg::pc_sel_e     pc_mux;
    if_ctrl_pkg::exc_pc_sel_e exc_pc_mux;
    logic [4:0]               irq_id;
    logic [31:0]              target;
    logic                     rand_ready;
    logic                     pmp;
    logic [31:0]              first_pc;
    logic [7:0]               nwords;
  } row_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic [31:0]            boot_addr_i;
  logic                   req_i;
  if_bus_pkg::instr_req_t instr_req_o;
  if_bus_pkg::instr_rsp_t instr_rsp_i;
  if_ctrl_pkg::pc_ctrl_t  ctrl_i;
  logic [31:0]            csr_mtvec_i;
  logic [31:0]            csr_mepc_i;
  logic [31:0]            csr_depc_i;
  logic                   pmp_err_if_i;
  logic                   id_in_ready_i;
  logic                   instr_valid_clear_i;
  logic                   instr_valid_id_o;
  logic                   instr_new_id_o;
  if_ctrl_pkg::id_instr_t id_o;
  logic [31:0]            pc_if_o;
  logic [31:0]            pc_set_target_o;
  logic                   csr_mtvec_init_o;
  logic                   if_busy_o;

  row_t        rows[$];
  string       names[$];
  logic [31:0] got_pc[$];
  logic [31:0] got_data[$];
  logic        got_err[$];
  logic [31:0] got_head[$];
  logic [31:0] rng_state;
  logic        ready_random;
  int          err_cnt;
  int          fail_tests;
  int          cycle_cnt;

  if_stage #(
    .DmHaltAddr      (DmHalt),
    .DmExceptionAddr (DmExc),
    .FifoDepth       (2)
  ) dut_i (.*);

  // 8 ns clock
  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // run limit from the total word count
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MaxCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the DUT stopped delivering instructions");
    $display("Some tests failed");
    $finish;
  end

  // LCG step, returns a value in 0 .. range-1
  function automatic int unsigned next_rand(input int unsigned range);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return (rng_state >> 16) % range;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic add_row(input string name, input if_ctrl_pkg::pc_sel_e mux,
                         input if_ctrl_pkg::exc_pc_sel_e exc, input logic [4:0] irq,
                         input logic [31:0] target, input logic rnd, input logic pmp,
                         input logic [31:0] first, input logic [7:0] n);
    row_t row;
    row = '{mux, exc, irq, target, rnd, pmp, first, n};
    rows.push_back(row);
    names.push_back(name);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    logic [31:0] pend_addr[$];
    int          pend_due[$];
    int          mem_cyc;
    int          wait_cnt;
    mem_cyc  = 0;
    wait_cnt = 0;
    forever begin
      @(negedge clk_i);
      mem_cyc++;
      instr_rsp_i.gnt = (wait_cnt == 0);
      instr_rsp_i.rvalid = 1'b0;
      // in-order responses, head only
      if (pend_addr.size() > 0 && pend_due[0] <= mem_cyc) begin
        instr_rsp_i.rvalid = 1'b1;
        instr_rsp_i.rdata  = pend_addr[0] ^ DataXor;
        instr_rsp_i.err    = (pend_addr[0][31:12] == ErrPage);
      end
      // sample the handshake while all inputs are stable
      #2;
      // busy while the bus still owes a response
      compare_value("busy", 32'(pend_addr.size() != 0), 32'(if_busy_o));
      if (instr_rsp_i.rvalid) begin
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      if (instr_req_o.req && instr_rsp_i.gnt) begin
        pend_addr.push_back(instr_req_o.addr);
        pend_due.push_back(mem_cyc + 1 + int'(next_rand(3)));
        wait_cnt = next_rand(3);
      end else if (instr_req_o.req && wait_cnt > 0) begin
        wait_cnt--;
      end
    end
  end

  // decode readiness, random stretches when the row asks for it
  initial begin : ready_gen
    int stretch;
    stretch = 0;
    forever begin
      @(negedge clk_i);
      if (!ready_random) begin
        id_in_ready_i = 1'b1;
        stretch = 0;
      end else begin
        if (stretch == 0) begin
          id_in_ready_i = next_rand(2) != 0;
          stretch = 1 + next_rand(6);
        end
        stretch--;
      end
    end
  end

  // collect valid new instructions and watch the valid flag
  initial begin : monitor
    logic        prev_valid;
    logic        prev_clear;
    logic [31:0] prev_head;
    prev_valid = 1'b0;
    prev_clear = 1'b0;
    prev_head  = '0;
    forever begin
      @(negedge clk_i);
      #1;
      if (instr_new_id_o && instr_valid_id_o) begin
        got_pc.push_back(id_o.pc);
        got_data.push_back(id_o.rdata);
        got_err.push_back(id_o.fetch_err);
        // queue head pc in the cycle of the load
        got_head.push_back(prev_head);
      end
      if (prev_valid && !instr_valid_id_o && !prev_clear) begin
        $display("instr_valid_id_o dropped without instr_valid_clear_i");
        err_cnt++;
      end
      prev_valid = instr_valid_id_o;
      prev_clear = instr_valid_clear_i;
      prev_head  = pc_if_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test rows
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(input int r);
    row_t        row;
    int          errs_before;
    logic [31:0] exp_pc;
    logic        exp_err;
    row = rows[r];
    errs_before = err_cnt;
    // redirect with requests in flight
    if (r != 0) begin
      while (!if_busy_o) @(negedge clk_i);
    end
    ctrl_i.pc_set      = 1'b1;
    ctrl_i.pc_mux      = row.pc_mux;
    ctrl_i.exc_pc_mux  = row.exc_pc_mux;
    ctrl_i.irq_id      = row.irq_id;
    ctrl_i.jump_target = row.target;
    if (row.pc_mux == if_ctrl_pkg::PC_ERET) csr_mepc_i = row.target;
    if (row.pc_mux == if_ctrl_pkg::PC_DRET) csr_depc_i = row.target;
    pmp_err_if_i        = row.pmp;
    ready_random        = row.rand_ready;
    instr_valid_clear_i = 1'b1;
    #1;
    compare_value({names[r], " target"}, row.first_pc, pc_set_target_o);
    compare_value({names[r], " mtvec_init"}, 32'(row.pc_mux == if_ctrl_pkg::PC_BOOT),
                  32'(csr_mtvec_init_o));
    @(negedge clk_i);
    ctrl_i.pc_set       = 1'b0;
    instr_valid_clear_i = 1'b0;
    got_pc.delete();
    got_data.delete();
    got_err.delete();
    got_head.delete();
    while (got_pc.size() < row.nwords) @(negedge clk_i);
    for (int i = 0; i < row.nwords; i++) begin
      exp_pc  = row.first_pc + 32'(4 * i);
      exp_err = row.pmp | (exp_pc[31:12] == ErrPage);
      compare_value({names[r], " pc"}, exp_pc, got_pc[i]);
      compare_value({names[r], " pc_if"}, exp_pc, got_head[i]);
      compare_value({names[r], " data"}, exp_pc ^ DataXor, got_data[i]);
      compare_value({names[r], " err"}, 32'(exp_err), 32'(got_err[i]));
    end
    if (err_cnt == errs_before) begin
      $display("test %s: ok", names[r]);
    end else begin
      $display("test %s: %0d mismatches", names[r], err_cnt - errs_before);
      fail_tests++;
    end
  endtask

  initial begin : main_seq
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    boot_addr_i         = 32'h0000_1000;
    instr_rsp_i         = '0;
    ctrl_i              = '0;
    csr_mtvec_i         = 32'h0000_2001;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    pmp_err_if_i        = 1'b0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    ready_random        = 1'b0;
    rng_state           = 32'hbbe7_0f26;
    err_cnt             = 0;
    fail_tests          = 0;
    add_row("boot", if_ctrl_pkg::PC_BOOT, if_ctrl_pkg::EXC_PC_EXC, 5'd0, 32'h0,
            1'b0, 1'b0, 32'h0000_1000, 8'd8);
    add_row("jump", if_ctrl_pkg::PC_JUMP, if_ctrl_pkg::EXC_PC_EXC, 5'd0,
            32'h0000_1840, 1'b0, 1'b0, 32'h0000_1840, 8'd6);
    add_row("exc", if_ctrl_pkg::PC_EXC, if_ctrl_pkg::EXC_PC_EXC, 5'd0, 32'h0,
            1'b0, 1'b0, 32'h0000_2000, 8'd4);
    add_row("irq", if_ctrl_pkg::PC_EXC, if_ctrl_pkg::EXC_PC_IRQ, 5'd5, 32'h0,
            1'b0, 1'b0, 32'h0000_2014, 8'd4);
    add_row("dbg_halt", if_ctrl_pkg::PC_EXC, if_ctrl_pkg::EXC_PC_DBD, 5'd0, 32'h0,
            1'b0, 1'b0, DmHalt, 8'd4);
    add_row("dbg_exc", if_ctrl_pkg::PC_EXC, if_ctrl_pkg::EXC_PC_DBG_EXC, 5'd0,
            32'h0, 1'b0, 1'b0, DmExc, 8'd4);
    add_row("eret", if_ctrl_pkg::PC_ERET, if_ctrl_pkg::EXC_PC_EXC, 5'd0,
            32'h0000_4100, 1'b0, 1'b0, 32'h0000_4100, 8'd4);
    add_row("dret", if_ctrl_pkg::PC_DRET, if_ctrl_pkg::EXC_PC_EXC, 5'd0,
            32'h0000_5200, 1'b0, 1'b0, 32'h0000_5200, 8'd4);
    add_row("bus_err", if_ctrl_pkg::PC_JUMP, if_ctrl_pkg::EXC_PC_EXC, 5'd0,
            32'h0000_3000, 1'b0, 1'b0, 32'h0000_3000, 8'd5);
    add_row("pmp_err", if_ctrl_pkg::PC_JUMP, if_ctrl_pkg::EXC_PC_EXC, 5'd0,
            32'h0000_6000, 1'b0, 1'b1, 32'h0000_6000, 8'd4);
    add_row("stall", if_ctrl_pkg::PC_JUMP, if_ctrl_pkg::EXC_PC_EXC, 5'd0,
            32'h0000_7000, 1'b1, 1'b0, 32'h0000_7000, 8'd24);
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    req_i  = 1'b1;
    for (int r = 0; r < rows.size(); r++) begin
      run_row(r);
    end
    $display("tests %0d, failed %0d, mismatches %0d", rows.size(), fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
if_ctrl_pkg.sv
if_bus_pkg.sv
if_pc_select.sv
fetch_fifo.sv
if_prefetch.sv
if_id_reg.sv
if_stage.sv
if_stage_asserts.sv
tb_if_stage.sv

// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

TOP := tb_if_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "Some tests failed" sim.log; then exit 1; fi; \
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)
	verilator --lint-only -Wall if_ctrl_pkg.sv if_bus_pkg.sv if_pc_select.sv \
		fetch_fifo.sv if_prefetch.sv if_id_reg.sv if_stage.sv --top-module if_stage

clean:
	rm -rf obj_dir sim.log
